/* design/attn_pkg.sv */
`default_nettype none

package attn_pkg;

    localparam int N_TOKENS   = 4;
    localparam int HEAD_DIM   = 8;   // channels per token
    localparam int TIME_STEPS = 4;
    localparam int SCORE_W    = 4;   // 0..HEAD_DIM
    localparam int ACC_W      = 6;   // 0..N_TOKENS*HEAD_DIM
    localparam int ACC_MAX    = N_TOKENS * HEAD_DIM;
    localparam int TOKEN_W    = 2;
    localparam int THR_W      = 8;
    localparam int N_PAIRS    = N_TOKENS * N_TOKENS;

    // spike of channel c at step t sits at bit t*HEAD_DIM + c
    typedef logic [TIME_STEPS-1:0][HEAD_DIM-1:0] spike_row_t;

    typedef logic [TIME_STEPS-1:0][SCORE_W-1:0] score_t;

    typedef logic [TOKEN_W-1:0] token_t;

    typedef struct packed {
        token_t q;   // query token, upper half
        token_t k;   // key token
    } pair_idx_t;

    typedef struct packed {
        token_t     token;
        spike_row_t spikes;
    } out_row_t;

    typedef enum logic [1:0] {
        IDLE,
        SCORE,
        FLUSH,
        ACCUM
    } attn_state_e;

    // decoded from word address bits 3:2
    typedef enum logic [1:0] {
        SEL_Q,
        SEL_K,
        SEL_V,
        SEL_CTRL
    } reg_sel_e;

endpackage

`default_nettype wire

/* design/wb_pkg.sv */
`default_nettype none

package wb_pkg;

    localparam int WB_ADR_W = 4;    // word address
    localparam int WB_DAT_W = 32;

    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [WB_ADR_W-1:0] adr;
        logic [WB_DAT_W-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic                ack;
        logic [WB_DAT_W-1:0] dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

/* design/qkv_spike_store.sv */
`timescale 1ns/1ps
`default_nettype none

module qkv_spike_store (
    input  wire                                             i_clk,
    input  wire                                             i_reset,
    input  wb_pkg::wb_req_t                                 i_wb,
    output wb_pkg::wb_rsp_t                                 o_wb,
    input  wire                                             i_busy,
    input  wire                                             i_done,
    output logic                                            o_start,
    output logic [attn_pkg::THR_W-1:0]                      o_threshold,
    output attn_pkg::spike_row_t [attn_pkg::N_TOKENS-1:0]   o_q,
    output attn_pkg::spike_row_t [attn_pkg::N_TOKENS-1:0]   o_k,
    output attn_pkg::spike_row_t [attn_pkg::N_TOKENS-1:0]   o_v
);
    import attn_pkg::*;
    import wb_pkg::*;

    reg_sel_e              sel;
    token_t                tok;
    logic                  req;
    logic                  ack_q;
    logic                  done_q;   // sticky until next start
    logic [WB_DAT_W-1:0]   rdata_q;

    assign sel = reg_sel_e'(i_wb.adr[3:2]);
    assign tok = token_t'(i_wb.adr[1:0]);
    assign req = i_wb.cyc && i_wb.stb && !ack_q;   // one ack per held request

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            ack_q       <= 1'b0;
            o_start     <= 1'b0;
            done_q      <= 1'b0;
            o_threshold <= '0;
            o_q         <= '0;
            o_k         <= '0;
            o_v         <= '0;
        end else begin
            ack_q   <= req;
            o_start <= 1'b0;
            if (i_done)
                done_q <= 1'b1;
            if (req && i_wb.we && !i_busy) begin   // writes during a run are dropped
                unique case (sel)
                    SEL_Q: o_q[tok] <= i_wb.dat;
                    SEL_K: o_k[tok] <= i_wb.dat;
                    SEL_V: o_v[tok] <= i_wb.dat;
                    SEL_CTRL: begin
                        o_threshold <= i_wb.dat[15:8];
                        if (i_wb.dat[0]) begin
                            o_start <= 1'b1;
                            done_q  <= 1'b0;
                        end
                    end
                endcase
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (req) begin
            unique case (sel)
                SEL_Q:    rdata_q <= o_q[tok];
                SEL_K:    rdata_q <= o_k[tok];
                SEL_V:    rdata_q <= o_v[tok];
                SEL_CTRL: rdata_q <= {30'd0, done_q, i_busy};
            endcase
        end
    end

    assign o_wb = wb_rsp_t'{ack: ack_q, dat: rdata_q};

    // host keeps cyc and stb up until it has seen ack
    a_ack_in_cycle: assert property (@(posedge i_clk) disable iff (i_reset)
        o_wb.ack |-> i_wb.cyc && i_wb.stb);

endmodule

`default_nettype wire

/* design/attn_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module attn_ctrl (
    input  wire  s_clk,
    input  wire  i_reset,
    input  wire  i_start,
    input  wire  i_last,
    output logic o_cnt_clear,
    output logic o_cnt_en,
    output logic o_score_en,
    output logic o_accum_en,
    output logic o_busy,
    output logic o_done
);
    import attn_pkg::*;

    attn_state_e state;
    attn_state_e state_nxt;

    always_comb begin
        state_nxt = state;
        unique case (state)
            IDLE:  if (i_start) state_nxt = SCORE;
            SCORE: if (i_last)  state_nxt = FLUSH;
            FLUSH: state_nxt = ACCUM;              // lets the last score land
            ACCUM: if (i_last)  state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge s_clk) begin
        if (i_reset) begin
            state  <= IDLE;
            o_done <= 1'b0;
        end else begin
            state  <= state_nxt;
            o_done <= (state == ACCUM) && i_last;  // lines up with the last row
        end
    end

    assign o_cnt_clear = (state == IDLE) || (state == FLUSH);
    assign o_cnt_en    = (state == SCORE) || (state == ACCUM);
    assign o_score_en  = (state == SCORE);
    assign o_accum_en  = (state == ACCUM);
    assign o_busy      = (state != IDLE);

    // store must hold off start while a run is in progress
    a_start_idle: assert property (@(posedge s_clk) disable iff (i_reset)
        i_start |-> state == IDLE);

endmodule

`default_nettype wire

/* design/pair_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module pair_counter (
    input  wire                 s_clk,
    input  wire                 i_reset,
    input  wire                 i_clear,
    input  wire                 i_en,
    output attn_pkg::pair_idx_t o_pair,
    output logic                o_last
);
    import attn_pkg::*;

    logic [$bits(pair_idx_t)-1:0] cnt;

    always_ff @(posedge s_clk) begin
        if (i_reset) begin
            cnt <= '0;
        end else if (i_clear) begin
            cnt <= '0;
        end else if (i_en) begin
            cnt <= cnt + 1'b1;   // wraps 15 -> 0
        end
    end

    assign o_pair = pair_idx_t'(cnt);
    assign o_last = (cnt == ($bits(pair_idx_t))'(N_PAIRS - 1));

endmodule

`default_nettype wire

/* design/spike_score_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module spike_score_unit (
    input  wire                  s_clk,
    input  wire                  i_reset,
    input  wire                  i_en,
    input  attn_pkg::pair_idx_t  i_pair,
    input  attn_pkg::spike_row_t i_q_row,
    input  attn_pkg::spike_row_t i_k_row,
    output attn_pkg::score_t     o_score,
    output attn_pkg::pair_idx_t  o_pair,
    output logic                 o_valid
);
    import attn_pkg::*;

    spike_row_t hits;
    score_t     score_nxt;

    // per step popcount of coincident spikes
    always_comb begin
        hits = i_q_row & i_k_row;
        for (int t = 0; t < TIME_STEPS; t++) begin
            score_nxt[t] = '0;
            for (int c = 0; c < HEAD_DIM; c++)
                score_nxt[t] = score_nxt[t] + SCORE_W'(hits[t][c]);
        end
    end

    always_ff @(posedge s_clk) begin
        if (i_reset)
            o_valid <= 1'b0;
        else
            o_valid <= i_en;
    end

    always_ff @(posedge s_clk) begin
        o_score <= score_nxt;
        o_pair  <= i_pair;
    end

endmodule

`default_nettype wire

/* design/score_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module score_buffer (
    input  wire                 s_clk,
    input  wire                 i_reset,
    input  wire                 i_wr_en,
    input  attn_pkg::pair_idx_t i_wr_pair,
    input  attn_pkg::score_t    i_score,
    input  attn_pkg::pair_idx_t i_rd_pair,
    output attn_pkg::score_t    o_score
);
    import attn_pkg::*;

    score_t mem [N_PAIRS];

    always_ff @(posedge s_clk) begin
        if (i_reset) begin
            mem <= '{default: '0};   // reads zero until a run fills it
        end else if (i_wr_en) begin
            mem[i_wr_pair] <= i_score;
        end
    end

    assign o_score = mem[i_rd_pair];   // comb read for the accumulator

endmodule

`default_nettype wire

/* design/attn_v_accum.sv */
`timescale 1ns/1ps
`default_nettype none

module attn_v_accum (
    input  wire                        s_clk,
    input  wire                        i_reset,
    input  wire                        i_en,
    input  attn_pkg::pair_idx_t        i_pair,
    input  attn_pkg::score_t           i_score,
    input  attn_pkg::spike_row_t       i_v_row,
    input  wire [attn_pkg::THR_W-1:0]  i_threshold,
    output attn_pkg::out_row_t         o_row,
    output logic                       o_row_valid
);
    import attn_pkg::*;

    logic [ACC_W-1:0] acc     [TIME_STEPS][HEAD_DIM];
    logic [ACC_W-1:0] acc_nxt [TIME_STEPS][HEAD_DIM];
    spike_row_t       fire;
    logic             last_key;

    assign last_key = (i_pair.k == token_t'(N_TOKENS - 1));

    always_comb begin
        for (int t = 0; t < TIME_STEPS; t++) begin
            for (int c = 0; c < HEAD_DIM; c++) begin
                acc_nxt[t][c] = acc[t][c];
                if (i_v_row[t][c])
                    acc_nxt[t][c] = acc[t][c] + ACC_W'(i_score[t]);
                fire[t][c] = ({{(THR_W - ACC_W){1'b0}}, acc_nxt[t][c]} >= i_threshold);
            end
        end
    end

    always_ff @(posedge s_clk) begin
        if (i_reset) begin
            acc         <= '{default: '0};
            o_row_valid <= 1'b0;
        end else begin
            o_row_valid <= i_en && last_key;
            if (i_en && last_key)
                acc <= '{default: '0};   // next query token starts fresh
            else if (i_en)
                acc <= acc_nxt;
        end
    end

    always_ff @(posedge s_clk) begin
        if (i_en && last_key)
            o_row <= '{token: i_pair.q, spikes: fire};
    end

    // at most four key tokens times eight coincidences
    for (genvar t = 0; t < TIME_STEPS; t++) begin : g_chk_t
        for (genvar c = 0; c < HEAD_DIM; c++) begin : g_chk_c
            a_acc_bound: assert property (@(posedge s_clk) disable iff (i_reset)
                i_en |-> acc_nxt[t][c] <= ACC_W'(ACC_MAX));
        end
    end

endmodule

`default_nettype wire

/* design/spike_attn_top.sv */
`timescale 1ns/1ps
`default_nettype none

module spike_attn_top (
    input  wire                s_clk,
    input  wire                i_reset,
    input  wb_pkg::wb_req_t    i_wb,
    output wb_pkg::wb_rsp_t    o_wb,
    output attn_pkg::out_row_t o_row,
    output logic               o_row_valid
);
    import attn_pkg::*;

    spike_row_t [N_TOKENS-1:0] w_q;
    spike_row_t [N_TOKENS-1:0] w_k;
    spike_row_t [N_TOKENS-1:0] w_v;
    logic [THR_W-1:0]          w_threshold;
    logic                      w_start;
    logic                      w_busy;
    logic                      w_done;
    logic                      w_cnt_clear;
    logic                      w_cnt_en;
    logic                      w_score_en;
    logic                      w_accum_en;
    logic                      w_last;
    pair_idx_t                 w_pair;
    pair_idx_t                 w_wr_pair;
    score_t                    w_wr_score;
    logic                      w_wr_valid;
    score_t                    w_rd_score;

    qkv_spike_store u_store (
        .i_clk       (s_clk),
        .i_reset     (i_reset),
        .i_wb        (i_wb),
        .o_wb        (o_wb),
        .i_busy      (w_busy),
        .i_done      (w_done),
        .o_start     (w_start),
        .o_threshold (w_threshold),
        .o_q         (w_q),
        .o_k         (w_k),
        .o_v         (w_v)
    );

    attn_ctrl u_ctrl (
        .s_clk       (s_clk),
        .i_reset     (i_reset),
        .i_start     (w_start),
        .i_last      (w_last),
        .o_cnt_clear (w_cnt_clear),
        .o_cnt_en    (w_cnt_en),
        .o_score_en  (w_score_en),
        .o_accum_en  (w_accum_en),
        .o_busy      (w_busy),
        .o_done      (w_done)
    );

    pair_counter u_cnt (
        .s_clk   (s_clk),
        .i_reset (i_reset),
        .i_clear (w_cnt_clear),
        .i_en    (w_cnt_en),
        .o_pair  (w_pair),
        .o_last  (w_last)
    );

    spike_score_unit u_score (
        .s_clk   (s_clk),
        .i_reset (i_reset),
        .i_en    (w_score_en),
        .i_pair  (w_pair),
        .i_q_row (w_q[w_pair.q]),
        .i_k_row (w_k[w_pair.k]),
        .o_score (w_wr_score),
        .o_pair  (w_wr_pair),
        .o_valid (w_wr_valid)
    );

    score_buffer u_sbuf (
        .s_clk     (s_clk),
        .i_reset   (i_reset),
        .i_wr_en   (w_wr_valid),
        .i_wr_pair (w_wr_pair),
        .i_score   (w_wr_score),
        .i_rd_pair (w_pair),
        .o_score   (w_rd_score)
    );

    attn_v_accum u_accum (
        .s_clk       (s_clk),
        .i_reset     (i_reset),
        .i_en        (w_accum_en),
        .i_pair      (w_pair),
        .i_score     (w_rd_score),
        .i_v_row     (w_v[w_pair.k]),
        .i_threshold (w_threshold),
        .o_row       (o_row),
        .o_row_valid (o_row_valid)
    );

endmodule

`default_nettype wire

/* tb/spike_attn_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module spike_attn_tb;
    import attn_pkg::*;
    import wb_pkg::*;

    localparam int RUNS         = 40;
    localparam int EXTRA_RUNS   = 4;     // readback plus the threshold edge runs
    localparam int RUN_CYCLES   = 160;   // load, start, 35 cycle run, status and readback
    localparam int LIMIT_CYCLES = (RUNS + EXTRA_RUNS) * RUN_CYCLES + 200;
    localparam logic [WB_ADR_W-1:0] ADR_CTRL = 4'hc;

    logic       s_clk;
    logic       i_reset;
    wb_req_t    wb_req;
    wb_rsp_t    wb_rsp;
    out_row_t   row;
    logic       row_valid;

    spike_row_t q_m [N_TOKENS];   // host copy of the stored words
    spike_row_t k_m [N_TOKENS];
    spike_row_t v_m [N_TOKENS];
    out_row_t   rows [$];

    spike_attn_top dut (
        .s_clk       (s_clk),
        .i_reset     (i_reset),
        .i_wb        (wb_req),
        .o_wb        (wb_rsp),
        .o_row       (row),
        .o_row_valid (row_valid)
    );

    initial s_clk = 1'b0;
    always #20 s_clk = ~s_clk;

    always @(negedge s_clk) begin
        if (row_valid)
            rows.push_back(row);
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [WB_DAT_W-1:0] exp, act);
        if (act !== exp)
            report_failure($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_row(input string name, input out_row_t exp, act);
        if (act !== exp)
            report_failure($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_status(input string name, input logic [1:0] exp, act);
        if (act !== exp)
            report_failure($sformatf("[ERROR] %s: expected %b, actual %b", name, exp, act));
    endtask

    // single classic cycle, held until ack
    task automatic wb_xfer(input logic we, input logic [WB_ADR_W-1:0] adr,
                           input logic [WB_DAT_W-1:0] wdat, output logic [WB_DAT_W-1:0] rdat);
        @(posedge s_clk);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        @(negedge s_clk);
        while (!wb_rsp.ack)
            @(negedge s_clk);
        rdat = wb_rsp.dat;
        @(posedge s_clk);
        wb_req <= '0;
    endtask

    task automatic wb_write(input logic [WB_ADR_W-1:0] adr, input logic [WB_DAT_W-1:0] dat);
        logic [WB_DAT_W-1:0] unused;
        wb_xfer(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input logic [WB_ADR_W-1:0] adr, output logic [WB_DAT_W-1:0] dat);
        wb_xfer(1'b0, adr, '0, dat);
    endtask

    task automatic randomize_words();
        for (int i = 0; i < N_TOKENS; i++) begin
            q_m[i] = $urandom();
            k_m[i] = $urandom();
            v_m[i] = $urandom();
        end
    endtask

    task automatic load_words();
        for (int i = 0; i < N_TOKENS; i++) begin
            wb_write(WB_ADR_W'(i), q_m[i]);
            wb_write(WB_ADR_W'(4 + i), k_m[i]);
            wb_write(WB_ADR_W'(8 + i), v_m[i]);
        end
    endtask

    task automatic check_stored(input string name);
        logic [WB_DAT_W-1:0] d;
        for (int i = 0; i < N_TOKENS; i++) begin
            wb_read(WB_ADR_W'(i), d);
            check_word({name, " q"}, q_m[i], d);
            wb_read(WB_ADR_W'(4 + i), d);
            check_word({name, " k"}, k_m[i], d);
            wb_read(WB_ADR_W'(8 + i), d);
            check_word({name, " v"}, v_m[i], d);
        end
    endtask

    // score = coincident q/k spikes per step, summed over keys where v spikes
    function automatic out_row_t model_row(input token_t qt, input logic [THR_W-1:0] thr);
        out_row_t r;
        int       sum;
        r.token = qt;
        for (int t = 0; t < TIME_STEPS; t++) begin
            for (int c = 0; c < HEAD_DIM; c++) begin
                sum = 0;
                for (int k = 0; k < N_TOKENS; k++) begin
                    if (v_m[k][t][c])
                        sum += $countones(q_m[qt][t] & k_m[k][t]);
                end
                r.spikes[t][c] = (sum >= int'(thr));
            end
        end
        return r;
    endfunction

    task automatic run_and_check(input string name, input logic [THR_W-1:0] thr,
                                 input logic protect);
        out_row_t            exp [N_TOKENS];
        logic [WB_DAT_W-1:0] st;
        for (int i = 0; i < N_TOKENS; i++)
            exp[i] = model_row(token_t'(i), thr);
        rows.delete();
        wb_write(ADR_CTRL, {16'd0, thr, 7'd0, 1'b1});
        wb_read(ADR_CTRL, st);
        check_status({name, " busy"}, 2'b01, st[1:0]);   // done cleared by the start
        if (protect) begin
            wb_write(WB_ADR_W'($urandom_range(0, 3)), ~q_m[0]);
            wb_write(WB_ADR_W'($urandom_range(4, 7)), ~k_m[1]);
            wb_write(WB_ADR_W'($urandom_range(8, 11)), ~v_m[2]);
        end
        while (rows.size() < N_TOKENS)
            @(negedge s_clk);
        for (int i = 0; i < N_TOKENS; i++)
            check_row({name, " row"}, exp[i], rows[i]);
        wb_read(ADR_CTRL, st);
        check_status({name, " done"}, 2'b10, st[1:0]);
        if (protect)
            check_stored({name, " protect"});
    endtask

    task automatic check_pattern(input string name, input spike_row_t pattern);
        for (int i = 0; i < N_TOKENS; i++)
            check_row({name, " fixed"}, out_row_t'{token: token_t'(i), spikes: pattern}, rows[i]);
    endtask

    initial begin
        i_reset <= 1'b1;
        wb_req  <= '0;
        void'($urandom(32'h244b));
        repeat (3) @(posedge s_clk);
        i_reset <= 1'b0;

        randomize_words();
        load_words();
        check_stored("readback");

        for (int n = 0; n < RUNS; n++) begin
            randomize_words();
            load_words();
            run_and_check($sformatf("run %0d", n), THR_W'($urandom_range(0, 20)), (n % 4) == 3);
        end

        randomize_words();
        load_words();
        run_and_check("thr zero", 8'd0, 1'b0);
        check_pattern("thr zero", '1);

        randomize_words();
        load_words();
        run_and_check("thr high", THR_W'(33 + $urandom_range(0, 222)), 1'b0);
        check_pattern("thr high", '0);

        for (int i = 0; i < N_TOKENS; i++) begin
            q_m[i] = '1;
            k_m[i] = '1;
            v_m[i] = '1;
        end
        load_words();
        run_and_check("all ones", 8'd32, 1'b0);
        check_pattern("all ones", '1);

        $display("Everything OK");
        $finish;
    end

    initial begin
        repeat (LIMIT_CYCLES) @(posedge s_clk);
        report_failure("timeout: the tests did not finish in the expected number of cycles");
    end

endmodule

`default_nettype wire

/* build.f */
design/attn_pkg.sv
design/wb_pkg.sv
design/qkv_spike_store.sv
design/attn_ctrl.sv
design/pair_counter.sv
design/spike_score_unit.sv
design/score_buffer.sv
design/attn_v_accum.sv
design/spike_attn_top.sv
tb/spike_attn_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module spike_attn_tb -f build.f -o spike_attn_sim

./obj_dir/spike_attn_sim | tee sim.log

if grep -q "^Everything OK$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
